// File: design/md_glue_params.svh
`ifndef MD_GLUE_PARAMS_SVH
`define MD_GLUE_PARAMS_SVH

// 68000 side bus widths
`define MD_VA_W 23
`define MD_VD_W 16

// Z80 side bus widths
`define MD_ZA_W 16
`define MD_ZD_W 8

// work RAM address widths
`define MD_WRAM_AW 15
`define MD_ZRAM_AW 13

// audio sample widths
`define MD_FM_W 9
`define MD_FM2612_W 10
`define MD_PSG_W 16
`define MD_MIX2612_W 18

// midpoint of the unsigned linear FM sample
`define MD_FM_BIAS 256

`endif

// File: design/md_glue_pkg.sv
`default_nettype none
`include "md_glue_params.svh"

package md_glue_pkg;

	// one data driver, byte lane enables and data
	typedef struct packed {
		logic en_u;
		logic en_l;
		logic [`MD_VD_W-1:0] data;
	} vd_drv_t;

	// one address driver, per bit enable mask
	typedef struct packed {
		logic [`MD_VA_W-1:0] en;
		logic [`MD_VA_W-1:0] addr;
	} va_drv_t;

	// one 68000 side master
	typedef struct packed {
		vd_drv_t vd;
		va_drv_t va;
		logic s_en;
		logic as;
		logic uds;
		logic lds;
		logic rw_en;
		logic rw;
	} m68k_drv_t;

	// pull down requests, already wired over all pullers
	typedef struct packed {
		logic dtack;
		logic bgack;
		logic br;
		logic ipl1;
		logic ipl2;
		logic reset;
		logic halt;
	} ctrl_pull_t;

	typedef struct packed {
		logic [`MD_VD_W-1:0] vd;
		logic [`MD_VA_W-1:0] va;
		logic as;
		logic uds;
		logic lds;
		logic rw;
	} m68k_bus_t;

	// 68000 control inputs, all active low
	typedef struct packed {
		logic dtack;
		logic bgack;
		logic br;
		logic [2:0] ipl;
		logic reset;
		logic halt;
	} cpu_ctrl_t;

	// one Z80 side master
	typedef struct packed {
		logic zd_en;
		logic [`MD_ZD_W-1:0] zd;
		logic za_en;
		logic [`MD_ZA_W-1:0] za;
		logic rd_en;
		logic rd;
		logic wr_en;
		logic wr;
		logic mreq_en;
		logic mreq;
	} z80_drv_t;

	typedef struct packed {
		logic [`MD_ZD_W-1:0] zd;
		logic [`MD_ZA_W-1:0] za;
		logic zrd;
		logic zwr;
		logic mreq;
	} z80_bus_t;

	// active low strobes from the system chip
	typedef struct packed {
		logic eoe;
		logic noe;
		logic ras0;
		logic uwr;
		logic lwr;
		logic zram;
		logic ce0;
		logic cas0;
		logic cas2;
		logic time_n;
		logic ia14;
	} board_strobe_t;

	typedef struct packed {
		logic [`MD_WRAM_AW-1:0] addr;
		logic [1:0] be;
		logic [`MD_VD_W-1:0] wdata;
		logic wren;
	} wram_req_t;

	typedef struct packed {
		logic [`MD_ZRAM_AW-1:0] addr;
		logic [`MD_ZD_W-1:0] wdata;
		logic wren;
	} zram_req_t;

	typedef struct packed {
		logic m3;
		logic m3_pause;
		logic data_en;
		logic [`MD_VD_W-1:0] data;
	} cart_in_t;

	// slot pins, active high as driven
	typedef struct packed {
		logic [`MD_VA_W-1:0] addr;
		logic cs;
		logic oe;
		logic lwr;
		logic uwr;
		logic time_sel;
		logic cas2;
		logic dma;
		logic [`MD_VD_W-1:0] wdata;
	} cart_out_t;

	typedef struct packed {
		logic [`MD_FM_W-1:0] mol;
		logic [`MD_FM_W-1:0] mor;
		logic [`MD_FM2612_W-1:0] mol_2612;
		logic [`MD_FM2612_W-1:0] mor_2612;
		logic [`MD_PSG_W-1:0] psg;
	} fm_in_t;

	typedef struct packed {
		logic [`MD_PSG_W-1:0] a_l;
		logic [`MD_PSG_W-1:0] a_r;
		logic [`MD_MIX2612_W-1:0] a_l_2612;
		logic [`MD_MIX2612_W-1:0] a_r_2612;
	} audio_mix_t;

endpackage

`default_nettype wire

// File: design/m68k_bus_merge.sv
`timescale 1ns/1ps
`default_nettype none
`include "md_glue_params.svh"

module m68k_bus_merge
(
	input  wire                        MCLK2_i,
	input  wire                        arst_n_i,
	input  wire md_glue_pkg::m68k_drv_t  chip_drv_i,
	input  wire md_glue_pkg::m68k_drv_t  cpu_drv_i,
	input  wire md_glue_pkg::m68k_drv_t  cart_drv_i,
	input  wire md_glue_pkg::vd_drv_t    ram_drv_i,
	input  wire md_glue_pkg::ctrl_pull_t pull_i,
	input  wire                        ext_dtack_i,
	input  wire                        ext_vres_i,
	output md_glue_pkg::m68k_bus_t     bus_o,
	output md_glue_pkg::cpu_ctrl_t     ctrl_o
);

	// expand the two byte lane enables to a per bit mask
	function automatic logic [`MD_VD_W-1:0] lane_mask(input md_glue_pkg::vd_drv_t d);
		lane_mask = {{(`MD_VD_W/2){d.en_u}}, {(`MD_VD_W/2){d.en_l}}};
	endfunction

	logic [`MD_VD_W-1:0] vd_en;
	logic [`MD_VD_W-1:0] vd_val;
	logic [`MD_VA_W-1:0] va_en;
	logic [`MD_VA_W-1:0] va_val;
	logic [1:0] s_en;
	logic [1:0] rw_en;
	md_glue_pkg::m68k_bus_t bus_d;
	md_glue_pkg::m68k_bus_t bus_q;
	logic dtack_q;
	logic bgack_q;
	logic br_q;

	assign vd_en = lane_mask(chip_drv_i.vd) | lane_mask(cpu_drv_i.vd) |
		lane_mask(cart_drv_i.vd) | lane_mask(ram_drv_i);

	assign vd_val = (lane_mask(chip_drv_i.vd) & chip_drv_i.vd.data) |
		(lane_mask(cpu_drv_i.vd) & cpu_drv_i.vd.data) |
		(lane_mask(cart_drv_i.vd) & cart_drv_i.vd.data) |
		(lane_mask(ram_drv_i) & ram_drv_i.data);

	// the cart only forces the Mark-III bank bits
	assign va_en = chip_drv_i.va.en | cpu_drv_i.va.en | cart_drv_i.va.en;

	assign va_val = (chip_drv_i.va.en & chip_drv_i.va.addr) |
		(cpu_drv_i.va.en & cpu_drv_i.va.addr) |
		(cart_drv_i.va.en & cart_drv_i.va.addr);

	assign s_en = {chip_drv_i.s_en, cpu_drv_i.s_en};
	assign rw_en = {chip_drv_i.rw_en, cpu_drv_i.rw_en};

	always_comb
	begin
		// undriven bits keep their last value
		bus_d.vd = vd_val | (~vd_en & bus_q.vd);
		bus_d.va = va_val | (~va_en & bus_q.va);
		// undriven strobes float high
		bus_d.as = (|s_en) ? |(s_en & {chip_drv_i.as, cpu_drv_i.as}) : 1'b1;
		bus_d.uds = (|s_en) ? |(s_en & {chip_drv_i.uds, cpu_drv_i.uds}) : 1'b1;
		bus_d.lds = (|s_en) ? |(s_en & {chip_drv_i.lds, cpu_drv_i.lds}) : 1'b1;
		bus_d.rw = (|rw_en) ? |(rw_en & {chip_drv_i.rw, cpu_drv_i.rw}) : 1'b1;
	end

	always_ff @(posedge MCLK2_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			bus_q.vd <= '0;
			bus_q.va <= '0;
			bus_q.as <= 1'b1;
			bus_q.uds <= 1'b1;
			bus_q.lds <= 1'b1;
			bus_q.rw <= 1'b1;
			dtack_q <= 1'b1;
			bgack_q <= 1'b1;
			br_q <= 1'b1;
		end
		else
		begin
			bus_q <= bus_d;
			dtack_q <= ~(pull_i.dtack | ext_dtack_i);
			bgack_q <= ~pull_i.bgack;
			br_q <= ~pull_i.br;
		end
	end

	assign bus_o = bus_q;

	always_comb
	begin
		ctrl_o.dtack = dtack_q;
		ctrl_o.bgack = bgack_q;
		ctrl_o.br = br_q;
		// level 1 interrupt input is never pulled on this board
		ctrl_o.ipl = {~pull_i.ipl2, ~pull_i.ipl1, 1'b1};
		ctrl_o.reset = ~(pull_i.reset | ext_vres_i);
		ctrl_o.halt = ~pull_i.halt;
	end

endmodule

`default_nettype wire

// File: design/z80_bus_merge.sv
`timescale 1ns/1ps
`default_nettype none
`include "md_glue_params.svh"

module z80_bus_merge
(
	input  wire                      MCLK2_i,
	input  wire                      arst_n_i,
	input  wire md_glue_pkg::z80_drv_t chip_zdrv_i,
	input  wire md_glue_pkg::z80_drv_t cpu_zdrv_i,
	input  wire md_glue_pkg::z80_drv_t ram_zdrv_i,
	output md_glue_pkg::z80_bus_t    zbus_o
);

	logic [2:0] zd_en;
	logic [`MD_ZD_W-1:0] zd_val;
	logic [1:0] za_en;
	logic [`MD_ZA_W-1:0] za_val;
	md_glue_pkg::z80_bus_t zbus_d;
	md_glue_pkg::z80_bus_t zbus_q;

	assign zd_en = {chip_zdrv_i.zd_en, cpu_zdrv_i.zd_en, ram_zdrv_i.zd_en};

	assign zd_val = ({`MD_ZD_W{chip_zdrv_i.zd_en}} & chip_zdrv_i.zd) |
		({`MD_ZD_W{cpu_zdrv_i.zd_en}} & cpu_zdrv_i.zd) |
		({`MD_ZD_W{ram_zdrv_i.zd_en}} & ram_zdrv_i.zd);

	// only the two masters put out addresses
	assign za_en = {chip_zdrv_i.za_en, cpu_zdrv_i.za_en};

	assign za_val = ({`MD_ZA_W{chip_zdrv_i.za_en}} & chip_zdrv_i.za) |
		({`MD_ZA_W{cpu_zdrv_i.za_en}} & cpu_zdrv_i.za);

	always_comb
	begin
		// an idle data bus is pulled up
		zbus_d.zd = (|zd_en) ? zd_val : {`MD_ZD_W{1'b1}};
		zbus_d.za = (|za_en) ? za_val : zbus_q.za;
		zbus_d.zrd = (chip_zdrv_i.rd_en | cpu_zdrv_i.rd_en) ?
			((chip_zdrv_i.rd_en & chip_zdrv_i.rd) | (cpu_zdrv_i.rd_en & cpu_zdrv_i.rd)) : 1'b1;
		zbus_d.zwr = (chip_zdrv_i.wr_en | cpu_zdrv_i.wr_en) ?
			((chip_zdrv_i.wr_en & chip_zdrv_i.wr) | (cpu_zdrv_i.wr_en & cpu_zdrv_i.wr)) : 1'b1;
		zbus_d.mreq = (chip_zdrv_i.mreq_en | cpu_zdrv_i.mreq_en) ?
			((chip_zdrv_i.mreq_en & chip_zdrv_i.mreq) |
			(cpu_zdrv_i.mreq_en & cpu_zdrv_i.mreq)) : 1'b1;
	end

	always_ff @(posedge MCLK2_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			zbus_q.zd <= {`MD_ZD_W{1'b1}};
			zbus_q.za <= '0;
			zbus_q.zrd <= 1'b1;
			zbus_q.zwr <= 1'b1;
			zbus_q.mreq <= 1'b1;
		end
		else
		begin
			zbus_q <= zbus_d;
		end
	end

	assign zbus_o = zbus_q;

endmodule

`default_nettype wire

// File: design/cart_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "md_glue_params.svh"

module cart_port
(
	input  wire                           MCLK2_i,
	input  wire                           arst_n_i,
	input  wire md_glue_pkg::cart_in_t      cart_i,
	input  wire md_glue_pkg::board_strobe_t strobe_i,
	input  wire md_glue_pkg::m68k_bus_t     bus_i,
	input  wire md_glue_pkg::cpu_ctrl_t     ctrl_i,
	output md_glue_pkg::m68k_drv_t        cart_drv_o,
	output md_glue_pkg::cart_out_t        cart_o
);

	logic m3_q;

	// Mark-III mode pin comes from the slot asynchronously
	always_ff @(posedge MCLK2_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			m3_q <= 1'b0;
		end
		else
		begin
			m3_q <= cart_i.m3;
		end
	end

	always_comb
	begin
		// upper lane only in Mark-III mode
		cart_drv_o.vd.en_u = m3_q & cart_i.data_en;
		cart_drv_o.vd.en_l = cart_i.data_en;
		cart_drv_o.vd.data = cart_i.data;
		// bank bits 22:20 forced while in Mark-III mode
		cart_drv_o.va.en = {{3{m3_q}}, {(`MD_VA_W-3){1'b0}}};
		cart_drv_o.va.addr = {~cart_i.m3_pause, 1'b0, 1'b1, {(`MD_VA_W-3){1'b0}}};
		// no strobes from the slot
		cart_drv_o.s_en = 1'b0;
		cart_drv_o.as = 1'b0;
		cart_drv_o.uds = 1'b0;
		cart_drv_o.lds = 1'b0;
		cart_drv_o.rw_en = 1'b0;
		cart_drv_o.rw = 1'b0;
	end

	always_comb
	begin
		cart_o.addr = bus_i.va;
		cart_o.cs = ~strobe_i.ce0;
		cart_o.oe = ~strobe_i.cas0;
		cart_o.lwr = ~strobe_i.lwr;
		cart_o.uwr = ~strobe_i.uwr;
		cart_o.time_sel = ~strobe_i.time_n;
		cart_o.cas2 = ~strobe_i.cas2;
		// bus grant ack doubles as the slot dma line
		cart_o.dma = ~ctrl_i.bgack;
		cart_o.wdata = bus_i.vd;
	end

endmodule

`default_nettype wire

// File: design/work_ram_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "md_glue_params.svh"

module work_ram_port
(
	input  wire md_glue_pkg::board_strobe_t strobe_i,
	input  wire md_glue_pkg::m68k_bus_t     bus_i,
	input  wire md_glue_pkg::z80_bus_t      zbus_i,
	input  wire [`MD_VD_W-1:0]            ram_68k_q_i,
	input  wire [`MD_ZD_W-1:0]            ram_z80_q_i,
	output md_glue_pkg::wram_req_t        wram_o,
	output md_glue_pkg::zram_req_t        zram_o,
	output md_glue_pkg::vd_drv_t          ram_drv_o,
	output md_glue_pkg::z80_drv_t         ram_zdrv_o
);

	always_comb
	begin
		// bit 13 of the RAM address comes from the chip, not VA
		wram_o.addr = {bus_i.va[14], strobe_i.ia14, bus_i.va[12:0]};
		wram_o.be = {~strobe_i.uwr, ~strobe_i.lwr};
		wram_o.wdata = bus_i.vd;
		wram_o.wren = (~strobe_i.uwr | ~strobe_i.lwr) & ~strobe_i.ras0;

		zram_o.addr = zbus_i.za[`MD_ZRAM_AW-1:0];
		zram_o.wdata = zbus_i.zd;
		zram_o.wren = ~strobe_i.zram & ~zbus_i.zwr;
	end

	always_comb
	begin
		// each lane has its own output enable
		ram_drv_o.en_u = ~strobe_i.eoe & ~strobe_i.ras0;
		ram_drv_o.en_l = ~strobe_i.noe & ~strobe_i.ras0;
		ram_drv_o.data = ram_68k_q_i;

		ram_zdrv_o = '0;
		ram_zdrv_o.zd_en = ~strobe_i.zram & ~zbus_i.zrd;
		ram_zdrv_o.zd = ram_z80_q_i;
	end

endmodule

`default_nettype wire

// File: design/audio_mixer.sv
`timescale 1ns/1ps
`default_nettype none
`include "md_glue_params.svh"

module audio_mixer
(
	input  wire                    MCLK2_i,
	input  wire                    arst_n_i,
	input  wire md_glue_pkg::fm_in_t fm_i,
	output md_glue_pkg::audio_mix_t audio_o
);

	localparam logic [`MD_FM_W-1:0] fm_bias = `MD_FM_BIAS;

	logic [`MD_FM_W-1:0] mol_s;
	logic [`MD_FM_W-1:0] mor_s;
	md_glue_pkg::audio_mix_t mix_d;

	// unsigned biased sample to two's complement
	assign mol_s = fm_i.mol - fm_bias;
	assign mor_s = fm_i.mor - fm_bias;

	always_comb
	begin
		// linear path, sample times 64 plus psg
		mix_d.a_l = {mol_s[`MD_FM_W-1], mol_s, 6'h0} + fm_i.psg;
		mix_d.a_r = {mor_s[`MD_FM_W-1], mor_s, 6'h0} + fm_i.psg;

		// dac path, 192 = 128 + 64
		mix_d.a_l_2612 = {fm_i.mol_2612[`MD_FM2612_W-1], fm_i.mol_2612, 7'h0} +
			{{2{fm_i.mol_2612[`MD_FM2612_W-1]}}, fm_i.mol_2612, 6'h0} +
			{2'h0, fm_i.psg};
		mix_d.a_r_2612 = {fm_i.mor_2612[`MD_FM2612_W-1], fm_i.mor_2612, 7'h0} +
			{{2{fm_i.mor_2612[`MD_FM2612_W-1]}}, fm_i.mor_2612, 6'h0} +
			{2'h0, fm_i.psg};
	end

	always_ff @(posedge MCLK2_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			audio_o <= '0;
		end
		else
		begin
			audio_o <= mix_d;
		end
	end

endmodule

`default_nettype wire

// File: design/md_bus_glue.sv
`timescale 1ns/1ps
`default_nettype none
`include "md_glue_params.svh"

module md_bus_glue
(
	input  wire                           MCLK2_i,
	input  wire                           arst_n_i,
	input  wire md_glue_pkg::m68k_drv_t     chip_drv_i,
	input  wire md_glue_pkg::m68k_drv_t     cpu_drv_i,
	input  wire md_glue_pkg::ctrl_pull_t    pull_i,
	input  wire                           ext_dtack_i,
	input  wire                           ext_vres_i,
	input  wire md_glue_pkg::z80_drv_t      chip_zdrv_i,
	input  wire md_glue_pkg::z80_drv_t      cpu_zdrv_i,
	input  wire md_glue_pkg::board_strobe_t strobe_i,
	input  wire [`MD_VD_W-1:0]            ram_68k_q_i,
	input  wire [`MD_ZD_W-1:0]            ram_z80_q_i,
	input  wire md_glue_pkg::cart_in_t      cart_i,
	input  wire md_glue_pkg::fm_in_t        fm_i,
	output md_glue_pkg::m68k_bus_t        bus_o,
	output md_glue_pkg::cpu_ctrl_t        ctrl_o,
	output md_glue_pkg::z80_bus_t         zbus_o,
	output md_glue_pkg::wram_req_t        wram_o,
	output md_glue_pkg::zram_req_t        zram_o,
	output md_glue_pkg::cart_out_t        cart_o,
	output md_glue_pkg::audio_mix_t       audio_o
);

	md_glue_pkg::m68k_drv_t cart_drv;
	md_glue_pkg::vd_drv_t ram_drv;
	md_glue_pkg::z80_drv_t ram_zdrv;

	m68k_bus_merge u_m68k_merge
	(
		.MCLK2_i     (MCLK2_i),
		.arst_n_i    (arst_n_i),
		.chip_drv_i  (chip_drv_i),
		.cpu_drv_i   (cpu_drv_i),
		.cart_drv_i  (cart_drv),
		.ram_drv_i   (ram_drv),
		.pull_i      (pull_i),
		.ext_dtack_i (ext_dtack_i),
		.ext_vres_i  (ext_vres_i),
		.bus_o       (bus_o),
		.ctrl_o      (ctrl_o)
	);

	z80_bus_merge u_z80_merge
	(
		.MCLK2_i     (MCLK2_i),
		.arst_n_i    (arst_n_i),
		.chip_zdrv_i (chip_zdrv_i),
		.cpu_zdrv_i  (cpu_zdrv_i),
		.ram_zdrv_i  (ram_zdrv),
		.zbus_o      (zbus_o)
	);

	cart_port u_cart
	(
		.MCLK2_i    (MCLK2_i),
		.arst_n_i   (arst_n_i),
		.cart_i     (cart_i),
		.strobe_i   (strobe_i),
		.bus_i      (bus_o),
		.ctrl_i     (ctrl_o),
		.cart_drv_o (cart_drv),
		.cart_o     (cart_o)
	);

	work_ram_port u_ram
	(
		.strobe_i    (strobe_i),
		.bus_i       (bus_o),
		.zbus_i      (zbus_o),
		.ram_68k_q_i (ram_68k_q_i),
		.ram_z80_q_i (ram_z80_q_i),
		.wram_o      (wram_o),
		.zram_o      (zram_o),
		.ram_drv_o   (ram_drv),
		.ram_zdrv_o  (ram_zdrv)
	);

	audio_mixer u_audio
	(
		.MCLK2_i  (MCLK2_i),
		.arst_n_i (arst_n_i),
		.fm_i     (fm_i),
		.audio_o  (audio_o)
	);

endmodule

`default_nettype wire

// File: dv/md_bus_glue_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "md_glue_params.svh"

module md_bus_glue_tb;

	logic MCLK2;
	logic arst_n_i;
	md_glue_pkg::m68k_drv_t chip_drv_i;
	md_glue_pkg::m68k_drv_t cpu_drv_i;
	md_glue_pkg::ctrl_pull_t pull_i;
	logic ext_dtack_i;
	logic ext_vres_i;
	md_glue_pkg::z80_drv_t chip_zdrv_i;
	md_glue_pkg::z80_drv_t cpu_zdrv_i;
	md_glue_pkg::board_strobe_t strobe_i;
	logic [`MD_VD_W-1:0] ram_68k_q_i;
	logic [`MD_ZD_W-1:0] ram_z80_q_i;
	md_glue_pkg::cart_in_t cart_i;
	md_glue_pkg::fm_in_t fm_i;
	md_glue_pkg::m68k_bus_t bus_o;
	md_glue_pkg::cpu_ctrl_t ctrl_o;
	md_glue_pkg::z80_bus_t zbus_o;
	md_glue_pkg::wram_req_t wram_o;
	md_glue_pkg::zram_req_t zram_o;
	md_glue_pkg::cart_out_t cart_o;
	md_glue_pkg::audio_mix_t audio_o;

	// reference model state, mirrors the DUT registers
	md_glue_pkg::m68k_bus_t m_bus;
	md_glue_pkg::z80_bus_t m_zbus;
	md_glue_pkg::audio_mix_t m_audio;
	logic m_dtack;
	logic m_bgack;
	logic m_br;
	logic m_m3;

	logic [15:0] lfsr;
	int mismatch_count;
	int timeout_count;
	string test_name;

	md_bus_glue dut0
	(
		.MCLK2_i     (MCLK2),
		.arst_n_i    (arst_n_i),
		.chip_drv_i  (chip_drv_i),
		.cpu_drv_i   (cpu_drv_i),
		.pull_i      (pull_i),
		.ext_dtack_i (ext_dtack_i),
		.ext_vres_i  (ext_vres_i),
		.chip_zdrv_i (chip_zdrv_i),
		.cpu_zdrv_i  (cpu_zdrv_i),
		.strobe_i    (strobe_i),
		.ram_68k_q_i (ram_68k_q_i),
		.ram_z80_q_i (ram_z80_q_i),
		.cart_i      (cart_i),
		.fm_i        (fm_i),
		.bus_o       (bus_o),
		.ctrl_o      (ctrl_o),
		.zbus_o      (zbus_o),
		.wram_o      (wram_o),
		.zram_o      (zram_o),
		.cart_o      (cart_o),
		.audio_o     (audio_o)
	);

	always #4 MCLK2 = ~MCLK2;

	// galois lfsr, one step per bit taken
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++)
		begin
			v = {v[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		rand_bits = v;
	endfunction

	function automatic md_glue_pkg::m68k_drv_t rand_m68k_drv();
		logic [$bits(md_glue_pkg::m68k_drv_t)-1:0] raw;
		logic [63:0] r;
		logic [63:0] sel;
		md_glue_pkg::m68k_drv_t d;
		raw[63:0] = rand_bits(64);
		r = rand_bits($bits(md_glue_pkg::m68k_drv_t) - 64);
		raw[$bits(md_glue_pkg::m68k_drv_t)-1:64] = r[$bits(md_glue_pkg::m68k_drv_t)-65:0];
		d = raw;
		sel = rand_bits(2);
		// a quarter of the time this master stays off the bus
		if (sel[1:0] == 2'b00)
		begin
			d.vd.en_u = 1'b0;
			d.vd.en_l = 1'b0;
			d.va.en = '0;
			d.s_en = 1'b0;
			d.rw_en = 1'b0;
		end
		rand_m68k_drv = d;
	endfunction

	function automatic md_glue_pkg::z80_drv_t rand_z80_drv();
		logic [63:0] raw;
		logic [63:0] sel;
		md_glue_pkg::z80_drv_t d;
		raw = rand_bits($bits(md_glue_pkg::z80_drv_t));
		d = raw[$bits(md_glue_pkg::z80_drv_t)-1:0];
		sel = rand_bits(2);
		if (sel[1:0] == 2'b00)
		begin
			d.zd_en = 1'b0;
			d.za_en = 1'b0;
			d.rd_en = 1'b0;
			d.wr_en = 1'b0;
			d.mreq_en = 1'b0;
		end
		rand_z80_drv = d;
	endfunction

	// strobe or rw line, floats high when nobody drives it
	function automatic logic wired_level(input logic en_a, input logic lv_a,
		input logic en_b, input logic lv_b);
		if (!en_a && !en_b)
		begin
			wired_level = 1'b1;
		end
		else
		begin
			wired_level = (en_a && lv_a) || (en_b && lv_b);
		end
	endfunction

	function automatic md_glue_pkg::audio_mix_t mix_model(input md_glue_pkg::fm_in_t f);
		md_glue_pkg::audio_mix_t a;
		logic [31:0] v;
		v = (int'(f.mol) - `MD_FM_BIAS) * 64 + int'(f.psg);
		a.a_l = v[15:0];
		v = (int'(f.mor) - `MD_FM_BIAS) * 64 + int'(f.psg);
		a.a_r = v[15:0];
		v = int'($signed(f.mol_2612)) * 192 + int'(f.psg);
		a.a_l_2612 = v[17:0];
		v = int'($signed(f.mor_2612)) * 192 + int'(f.psg);
		a.a_r_2612 = v[17:0];
		mix_model = a;
	endfunction

	task automatic compare_bus(input string name, input md_glue_pkg::m68k_bus_t exp,
		input md_glue_pkg::m68k_bus_t act);
		if (act !== exp)
		begin
			$display("MISMATCH %s bus_o expected %h actual %h", name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic compare_ctrl(input string name, input md_glue_pkg::cpu_ctrl_t exp,
		input md_glue_pkg::cpu_ctrl_t act);
		if (act !== exp)
		begin
			$display("MISMATCH %s ctrl_o expected %h actual %h", name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic compare_zbus(input string name, input md_glue_pkg::z80_bus_t exp,
		input md_glue_pkg::z80_bus_t act);
		if (act !== exp)
		begin
			$display("MISMATCH %s zbus_o expected %h actual %h", name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic compare_wram(input string name, input md_glue_pkg::wram_req_t exp,
		input md_glue_pkg::wram_req_t act);
		if (act !== exp)
		begin
			$display("MISMATCH %s wram_o expected %h actual %h", name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic compare_zram(input string name, input md_glue_pkg::zram_req_t exp,
		input md_glue_pkg::zram_req_t act);
		if (act !== exp)
		begin
			$display("MISMATCH %s zram_o expected %h actual %h", name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic compare_cart(input string name, input md_glue_pkg::cart_out_t exp,
		input md_glue_pkg::cart_out_t act);
		if (act !== exp)
		begin
			$display("MISMATCH %s cart_o expected %h actual %h", name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic compare_audio(input string name, input md_glue_pkg::audio_mix_t exp,
		input md_glue_pkg::audio_mix_t act);
		if (act !== exp)
		begin
			$display("MISMATCH %s audio_o expected %h actual %h", name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic reset_model();
		m_bus = '0;
		m_bus.as = 1'b1;
		m_bus.uds = 1'b1;
		m_bus.lds = 1'b1;
		m_bus.rw = 1'b1;
		m_zbus.zd = '1;
		m_zbus.za = '0;
		m_zbus.zrd = 1'b1;
		m_zbus.zwr = 1'b1;
		m_zbus.mreq = 1'b1;
		m_dtack = 1'b1;
		m_bgack = 1'b1;
		m_br = 1'b1;
		m_m3 = 1'b0;
		m_audio = '0;
	endtask

	task automatic clear_inputs();
		chip_drv_i = '0;
		cpu_drv_i = '0;
		pull_i = '0;
		ext_dtack_i = 1'b0;
		ext_vres_i = 1'b0;
		chip_zdrv_i = '0;
		cpu_zdrv_i = '0;
		strobe_i = '0;
		ram_68k_q_i = '0;
		ram_z80_q_i = '0;
		cart_i = '0;
		fm_i = '0;
	endtask

	// m3_mode 0 and 1 hold the pin, 2 toggles it now and then
	task automatic drive_random(input int m3_mode);
		logic [63:0] r;
		logic m3_prev;
		m3_prev = cart_i.m3;
		chip_drv_i = rand_m68k_drv();
		cpu_drv_i = rand_m68k_drv();
		chip_zdrv_i = rand_z80_drv();
		cpu_zdrv_i = rand_z80_drv();
		r = rand_bits(9);
		pull_i = r[6:0];
		ext_dtack_i = r[7];
		ext_vres_i = r[8];
		r = rand_bits(11);
		strobe_i = r[10:0];
		r = rand_bits(24);
		ram_68k_q_i = r[15:0];
		ram_z80_q_i = r[23:16];
		r = rand_bits(18);
		cart_i = {1'b0, r[17:0]};
		cart_i.m3 = (m3_mode == 1);
		if (m3_mode == 2)
		begin
			r = rand_bits(3);
			cart_i.m3 = (r[2:0] == 3'b000) ? ~m3_prev : m3_prev;
		end
		r = rand_bits(54);
		fm_i = r[53:0];
	endtask

	// only the cart on the bus, Mark-III pin high
	task automatic drive_cart_only();
		logic [63:0] r;
		clear_inputs();
		strobe_i = '1;
		cart_i.m3 = 1'b1;
		cart_i.m3_pause = 1'b0;
		cart_i.data_en = 1'b1;
		cart_i.data = 16'h5AC3;
		r = rand_bits(54);
		fm_i = r[53:0];
	endtask

	task automatic check_outputs();
		md_glue_pkg::cpu_ctrl_t e_ctrl;
		md_glue_pkg::wram_req_t e_wram;
		md_glue_pkg::zram_req_t e_zram;
		md_glue_pkg::cart_out_t e_cart;
		e_ctrl.dtack = m_dtack;
		e_ctrl.bgack = m_bgack;
		e_ctrl.br = m_br;
		e_ctrl.ipl = {~pull_i.ipl2, ~pull_i.ipl1, 1'b1};
		e_ctrl.reset = ~(pull_i.reset | ext_vres_i);
		e_ctrl.halt = ~pull_i.halt;
		e_wram.addr = {m_bus.va[14], strobe_i.ia14, m_bus.va[12:0]};
		e_wram.be = {~strobe_i.uwr, ~strobe_i.lwr};
		e_wram.wdata = m_bus.vd;
		e_wram.wren = (!strobe_i.uwr || !strobe_i.lwr) && !strobe_i.ras0;
		e_zram.addr = m_zbus.za[`MD_ZRAM_AW-1:0];
		e_zram.wdata = m_zbus.zd;
		e_zram.wren = !strobe_i.zram && !m_zbus.zwr;
		e_cart.addr = m_bus.va;
		e_cart.cs = ~strobe_i.ce0;
		e_cart.oe = ~strobe_i.cas0;
		e_cart.lwr = ~strobe_i.lwr;
		e_cart.uwr = ~strobe_i.uwr;
		e_cart.time_sel = ~strobe_i.time_n;
		e_cart.cas2 = ~strobe_i.cas2;
		e_cart.dma = ~m_bgack;
		e_cart.wdata = m_bus.vd;
		compare_bus(test_name, m_bus, bus_o);
		compare_ctrl(test_name, e_ctrl, ctrl_o);
		compare_zbus(test_name, m_zbus, zbus_o);
		compare_wram(test_name, e_wram, wram_o);
		compare_zram(test_name, e_zram, zram_o);
		compare_cart(test_name, e_cart, cart_o);
		compare_audio(test_name, m_audio, audio_o);
	endtask

	// next register state from the inputs just driven
	task automatic advance_model();
		logic [3:0] en_u;
		logic [3:0] en_l;
		logic [`MD_VD_W-1:0] vdat [4];
		logic [`MD_VA_W-1:0] va_en [3];
		logic [`MD_VA_W-1:0] va_val [3];
		logic [2:0] zd_en;
		logic [`MD_ZD_W-1:0] zdat [3];
		md_glue_pkg::m68k_bus_t nb;
		md_glue_pkg::z80_bus_t nz;
		logic any;
		logic val;
		int b;
		int k;
		en_u = {!strobe_i.eoe && !strobe_i.ras0, m_m3 && cart_i.data_en,
			cpu_drv_i.vd.en_u, chip_drv_i.vd.en_u};
		en_l = {!strobe_i.noe && !strobe_i.ras0, cart_i.data_en,
			cpu_drv_i.vd.en_l, chip_drv_i.vd.en_l};
		vdat[0] = chip_drv_i.vd.data;
		vdat[1] = cpu_drv_i.vd.data;
		vdat[2] = cart_i.data;
		vdat[3] = ram_68k_q_i;
		va_en[0] = chip_drv_i.va.en;
		va_val[0] = chip_drv_i.va.addr;
		va_en[1] = cpu_drv_i.va.en;
		va_val[1] = cpu_drv_i.va.addr;
		// Mark-III bank forcing on bits 22:20
		va_en[2] = m_m3 ? 23'h700000 : 23'h0;
		va_val[2] = {~cart_i.m3_pause, 1'b0, 1'b1, 20'h0};
		for (b = 0; b < `MD_VD_W; b++)
		begin
			any = 1'b0;
			val = 1'b0;
			for (k = 0; k < 4; k++)
			begin
				if ((b >= `MD_VD_W / 2) ? en_u[k] : en_l[k])
				begin
					any = 1'b1;
					val = val | vdat[k][b];
				end
			end
			nb.vd[b] = any ? val : m_bus.vd[b];
		end
		for (b = 0; b < `MD_VA_W; b++)
		begin
			any = 1'b0;
			val = 1'b0;
			for (k = 0; k < 3; k++)
			begin
				if (va_en[k][b])
				begin
					any = 1'b1;
					val = val | va_val[k][b];
				end
			end
			nb.va[b] = any ? val : m_bus.va[b];
		end
		nb.as = wired_level(chip_drv_i.s_en, chip_drv_i.as, cpu_drv_i.s_en, cpu_drv_i.as);
		nb.uds = wired_level(chip_drv_i.s_en, chip_drv_i.uds, cpu_drv_i.s_en, cpu_drv_i.uds);
		nb.lds = wired_level(chip_drv_i.s_en, chip_drv_i.lds, cpu_drv_i.s_en, cpu_drv_i.lds);
		nb.rw = wired_level(chip_drv_i.rw_en, chip_drv_i.rw, cpu_drv_i.rw_en, cpu_drv_i.rw);

		zd_en = {!strobe_i.zram && !m_zbus.zrd, cpu_zdrv_i.zd_en, chip_zdrv_i.zd_en};
		zdat[0] = chip_zdrv_i.zd;
		zdat[1] = cpu_zdrv_i.zd;
		zdat[2] = ram_z80_q_i;
		nz.zd = '0;
		for (k = 0; k < 3; k++)
		begin
			if (zd_en[k])
			begin
				nz.zd = nz.zd | zdat[k];
			end
		end
		if (zd_en == 3'b000)
		begin
			nz.zd = '1;
		end
		nz.za = m_zbus.za;
		if (chip_zdrv_i.za_en || cpu_zdrv_i.za_en)
		begin
			nz.za = (chip_zdrv_i.za_en ? chip_zdrv_i.za : '0) |
				(cpu_zdrv_i.za_en ? cpu_zdrv_i.za : '0);
		end
		nz.zrd = wired_level(chip_zdrv_i.rd_en, chip_zdrv_i.rd, cpu_zdrv_i.rd_en, cpu_zdrv_i.rd);
		nz.zwr = wired_level(chip_zdrv_i.wr_en, chip_zdrv_i.wr, cpu_zdrv_i.wr_en, cpu_zdrv_i.wr);
		nz.mreq = wired_level(chip_zdrv_i.mreq_en, chip_zdrv_i.mreq,
			cpu_zdrv_i.mreq_en, cpu_zdrv_i.mreq);

		m_bus = nb;
		m_zbus = nz;
		m_dtack = ~(pull_i.dtack | ext_dtack_i);
		m_bgack = ~pull_i.bgack;
		m_br = ~pull_i.br;
		m_m3 = cart_i.m3;
		m_audio = mix_model(fm_i);
	endtask

	task automatic run_cycles(input string name, input int count, input int m3_mode);
		int n;
		test_name = name;
		for (n = 0; n < count; n++)
		begin
			@(negedge MCLK2);
			check_outputs();
			drive_random(m3_mode);
			advance_model();
		end
	endtask

	// cart alone on the bus until the forced bank shows up
	task automatic wait_mark3_forcing();
		int n;
		logic seen;
		test_name = "mark3_entry";
		seen = 1'b0;
		n = 0;
		while (!seen && n < 8)
		begin
			@(negedge MCLK2);
			check_outputs();
			seen = (bus_o.va[22:20] === 3'b101) && (bus_o.vd === 16'h5AC3);
			drive_cart_only();
			advance_model();
			n++;
		end
		if (!seen)
		begin
			$display("timeout: Mark-III address forcing never reached the 68000 bus");
			timeout_count++;
		end
	endtask

	initial
	begin
		int i;
		lfsr = 16'd26920;
		mismatch_count = 0;
		timeout_count = 0;
		MCLK2 = 1'b0;
		arst_n_i = 1'b0;
		clear_inputs();
		reset_model();
		test_name = "reset";
		// five rising edges under reset
		for (i = 0; i < 5; i++)
		begin
			@(negedge MCLK2);
			if (i > 0)
			begin
				check_outputs();
			end
		end
		arst_n_i = 1'b1;
		check_outputs();
		drive_random(0);
		advance_model();

		run_cycles("merge", 400, 0);
		wait_mark3_forcing();
		run_cycles("mark3", 300, 1);
		run_cycles("mixed", 300, 2);

		@(negedge MCLK2);
		check_outputs();
		$display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0)
		begin
			$display("TEST RESULT: PASS");
		end
		else
		begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/md_glue_pkg.sv
design/m68k_bus_merge.sv
design/z80_bus_merge.sv
design/cart_port.sv
design/work_ram_port.sv
design/audio_mixer.sv
design/md_bus_glue.sv
dv/md_bus_glue_tb.sv

// File: Bender.yml
package:
  name: md_bus_glue

sources:
  - include_dirs:
      - design
    files:
      - design/md_glue_pkg.sv
      - design/m68k_bus_merge.sv
      - design/z80_bus_merge.sv
      - design/cart_port.sv
      - design/work_ram_port.sv
      - design/audio_mixer.sv
      - design/md_bus_glue.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - dv/md_bus_glue_tb.sv
